/* logic/bht_settings.svh */
// ----------------------------
// sizes and init mask for the branch history table
// include wherever the macros are needed
// ----------------------------
`ifndef BHT_SETTINGS_SVH
`define BHT_SETTINGS_SVH

// entry shape
`define BHT_LANES 4
`define BHT_CNT_W 2
`define BHT_ADDR_W 10

// array shape
`define BHT_ROW_ADDR_W 9
`define BHT_ROW_W 16

// cleared counter reads back as this value
`define BHT_INIT_MASK 2'b01

`endif

/* logic/bht_pkg.sv */
// ----------------------------
// shared types for the branch history table
// ----------------------------
`include "bht_settings.svh"

package bht_pkg;

   typedef logic [`BHT_CNT_W-1:0] bht_cnt_t;
   typedef bht_cnt_t [`BHT_LANES-1:0] bht_entry_t;
   typedef logic [`BHT_ROW_ADDR_W-1:0] bht_row_t;

   // lane update request
   typedef struct packed {
      logic [`BHT_LANES-1:0]  w_act;
      logic [`BHT_ADDR_W-1:0] w_addr;
      bht_cnt_t               data_in;
   } bht_wr_req_t;

   typedef struct packed {
      logic                   r_act;
      logic [`BHT_ADDR_W-1:0] r_addr;
   } bht_rd_req_t;

   // array write port, sel is per bit
   typedef struct packed {
      logic                  en;
      bht_row_t              addr;
      logic [`BHT_ROW_W-1:0] sel;
      logic [`BHT_ROW_W-1:0] data;
   } bht_ary_wr_t;

endpackage

/* logic/bht_array.sv */
// ----------------------------
// 512 x 16 row memory, one read and one write port
// bit write enables, read data registered
// ----------------------------
`timescale 1ns/1ps
`include "bht_settings.svh"

module bht_array
   import bht_pkg::*;
(
   input  logic                  nclk,
   input  bht_ary_wr_t           ary_wr,
   input  logic                  rd_en,
   input  bht_row_t              rd_row,
   output logic [`BHT_ROW_W-1:0] rd_data
);

   localparam int DEPTH = 1 << `BHT_ROW_ADDR_W;

   logic [`BHT_ROW_W-1:0] mem [DEPTH];

   // ------------------------------
   // write port
   // ------------------------------
   always_ff @(posedge nclk) begin
      if (ary_wr.en) begin
         for (int b = 0; b < `BHT_ROW_W; b++) begin
            if (ary_wr.sel[b]) begin
               mem[ary_wr.addr][b] <= ary_wr.data[b];
            end
         end
      end
   end

   // ------------------------------
   // read port
   // ------------------------------
   // same row written this cycle returns the old contents
   always_ff @(posedge nclk) begin
      if (rd_en) begin
         rd_data <= mem[rd_row];
      end
   end

endmodule

/* logic/bht_init_sweep.sv */
// ----------------------------
// row counter for the init sweep
// advances while init_reset is held
// ----------------------------
`timescale 1ns/1ps

module bht_init_sweep
   import bht_pkg::*;
(
   input  logic     nclk,
   input  logic     reset,
   input  logic     init_reset,
   output bht_row_t sweep_row
);

   // wraps after the last row, no restart when init drops
   always_ff @(posedge nclk) begin
      if (reset) begin
         sweep_row <= '0;
      end else if (init_reset) begin
         sweep_row <= sweep_row + 1'b1;
      end
   end

   // counter frozen outside init
   a_sweep_hold: assert property (
      @(posedge nclk) disable iff (reset)
      !init_reset |=> $stable(sweep_row)
   ) else $error("sweep row moved while init was low");

endmodule

/* logic/bht_write_arb.sv */
// ----------------------------
// array write port arbiter, init sweep over lane update
// drops updates that hit the row being read
// ----------------------------
`timescale 1ns/1ps
`include "bht_settings.svh"

module bht_write_arb
   import bht_pkg::*;
(
   input  logic        init_reset,
   input  bht_row_t    sweep_row,
   input  bht_wr_req_t wr,
   input  bht_rd_req_t rd,
   output bht_ary_wr_t ary_wr
);

   localparam int HALF_W = `BHT_LANES * `BHT_CNT_W;
   localparam int HALVES = `BHT_ROW_W / HALF_W;

   logic                  upd_any;
   logic                  row_clash;
   logic                  upd_en;
   logic [`BHT_ROW_W-1:0] upd_sel;
   bht_cnt_t              stored;

   assign upd_any   = |wr.w_act;
   assign row_clash = rd.r_act &&
                      (rd.r_addr[`BHT_ADDR_W-1:1] == wr.w_addr[`BHT_ADDR_W-1:1]);
   assign upd_en    = upd_any && !row_clash;
   assign stored    = wr.data_in ^ `BHT_INIT_MASK;

   // lane enables fanned out into the half picked by addr bit 0
   always_comb begin
      upd_sel = '0;
      for (int h = 0; h < HALVES; h++) begin
         for (int l = 0; l < `BHT_LANES; l++) begin
            if (int'(wr.w_addr[0]) == h) begin
               upd_sel[h*HALF_W + l*`BHT_CNT_W +: `BHT_CNT_W] = {`BHT_CNT_W{wr.w_act[l]}};
            end
         end
      end
   end

   always_comb begin
      if (init_reset) begin
         ary_wr.en   = 1'b1;
         ary_wr.addr = sweep_row;
         ary_wr.sel  = '1;
         ary_wr.data = '0;
      end else begin
         ary_wr.en   = upd_en;
         ary_wr.addr = wr.w_addr[`BHT_ADDR_W-1:1];
         ary_wr.sel  = upd_sel;
         ary_wr.data = {(`BHT_ROW_W / `BHT_CNT_W){stored}};
      end
   end

   always_comb begin
      if (!init_reset && ary_wr.en && rd.r_act) begin
         assert (ary_wr.addr != rd.r_addr[`BHT_ADDR_W-1:1])
            else $error("update granted on the row under read");
      end
   end

endmodule

/* logic/bht_read_path.sv */
// ----------------------------
// read request regs, half select, unmask, write-through
// data_out loads two edges after the request is driven
// ----------------------------
`timescale 1ns/1ps
`include "bht_settings.svh"

module bht_read_path
   import bht_pkg::*;
(
   input  logic                  nclk,
   input  logic                  reset,
   input  bht_rd_req_t           rd,
   input  bht_wr_req_t           wr,
   output logic                  rd_en,
   output bht_row_t              rd_row,
   input  logic [`BHT_ROW_W-1:0] ary_rd_data,
   output bht_entry_t            data_out
);

   localparam int HALF_W = $bits(bht_entry_t);

   bht_rd_req_t rd_q;
   bht_wr_req_t wr_q;
   bht_entry_t  half_data;
   bht_entry_t  unmasked;
   bht_entry_t  data_out_d;
   logic        addr_match;

   assign rd_en  = rd.r_act;
   assign rd_row = rd.r_addr[`BHT_ADDR_W-1:1];

   // ------------------------------
   // request registers
   // ------------------------------
   always_ff @(posedge nclk) begin
      if (reset) begin
         rd_q <= '0;
         wr_q <= '0;
      end else begin
         rd_q.r_act <= rd.r_act;
         if (rd.r_act) begin
            rd_q.r_addr <= rd.r_addr;
         end
         wr_q.w_act <= wr.w_act;
         if (|wr.w_act) begin
            wr_q.w_addr  <= wr.w_addr;
            wr_q.data_in <= wr.data_in;
         end
      end
   end

   assign half_data = rd_q.r_addr[0] ? ary_rd_data[2*HALF_W-1:HALF_W]
                                     : ary_rd_data[HALF_W-1:0];
   assign unmasked  = half_data ^ {`BHT_LANES{`BHT_INIT_MASK}};

   // write of the same entry in the read cycle was dropped by the array
   assign addr_match = rd_q.r_act && (wr_q.w_addr == rd_q.r_addr);

   always_comb begin
      for (int l = 0; l < `BHT_LANES; l++) begin
         data_out_d[l] = (addr_match && wr_q.w_act[l]) ? wr_q.data_in : unmasked[l];
      end
   end

   always_ff @(posedge nclk) begin
      if (reset) begin
         data_out <= '0;
      end else if (rd_q.r_act) begin
         data_out <= data_out_d;
      end
   end

   a_raddr_known: assert property (
      @(posedge nclk) disable iff (reset)
      rd.r_act |-> !$isunknown(rd.r_addr)
   ) else $error("read address unknown with r_act set");

endmodule

/* logic/bht_top.sv */
// ----------------------------
// branch history table, 1024 entries of four 2-bit counters
// one read and one write request per cycle
// ----------------------------
`timescale 1ns/1ps
`include "bht_settings.svh"

module bht_top
   import bht_pkg::*;
(
   input  logic        nclk,
   input  logic        reset,
   input  logic        init_reset,
   input  bht_wr_req_t wr,
   input  bht_rd_req_t rd,
   output bht_entry_t  data_out
);

   bht_row_t              sweep_row;
   bht_ary_wr_t           ary_wr;
   logic                  rd_en;
   bht_row_t              rd_row;
   logic [`BHT_ROW_W-1:0] ary_rd_data;

   bht_init_sweep u_init_sweep (
      .nclk       (nclk),
      .reset      (reset),
      .init_reset (init_reset),
      .sweep_row  (sweep_row)
   );

   bht_write_arb u_write_arb (
      .init_reset (init_reset),
      .sweep_row  (sweep_row),
      .wr         (wr),
      .rd         (rd),
      .ary_wr     (ary_wr)
   );

   bht_array u_array (
      .nclk    (nclk),
      .ary_wr  (ary_wr),
      .rd_en   (rd_en),
      .rd_row  (rd_row),
      .rd_data (ary_rd_data)
   );

   bht_read_path u_read_path (
      .nclk        (nclk),
      .reset       (reset),
      .rd          (rd),
      .wr          (wr),
      .rd_en       (rd_en),
      .rd_row      (rd_row),
      .ary_rd_data (ary_rd_data),
      .data_out    (data_out)
   );

endmodule

/* dv/bht_tb.sv */
// ----------------------------
// testbench for bht_top, directed lines from dv/bht_stim.txt
// then random traffic, all reads checked against a model
// ----------------------------
`timescale 1ns/1ps
`include "bht_settings.svh"

module bht_tb
   import bht_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int INIT_CYCLES  = 1 << `BHT_ROW_ADDR_W;
   localparam int RAND_CYCLES  = 200;
   localparam int ENTRIES      = 1 << `BHT_ADDR_W;
   localparam bht_entry_t CLEARED = {`BHT_LANES{`BHT_INIT_MASK}};
   localparam bht_row_t   ONE_ROW = 1;

   typedef struct packed {
      logic        init;
      bht_rd_req_t rd;
      bht_wr_req_t wr;
      bht_entry_t  exp;
   } stim_line_t;

   // model read stage, file expectation rides along
   typedef struct packed {
      logic                   act;
      logic [`BHT_ADDR_W-1:0] addr;
      bht_entry_t             ent;
      logic                   fchk;
      bht_entry_t             fexp;
   } rd_stage_t;

   logic        nclk;
   logic        reset;
   logic        init_reset;
   bht_wr_req_t wr;
   bht_rd_req_t rd;
   bht_entry_t  data_out;
   logic        cur_fchk;
   bht_entry_t  cur_fexp;
   stim_line_t  stim_q[$];
   logic        stim_loaded;
   integer      seed;

   bht_entry_t  model_ent [ENTRIES];
   bht_row_t    model_sweep;
   rd_stage_t   s1;
   bht_wr_req_t s1_wr;
   bht_entry_t  exp_out;
   logic        out_fchk;
   bht_entry_t  out_fexp;

   bht_top u_bht_top (
      .nclk       (nclk),
      .reset      (reset),
      .init_reset (init_reset),
      .wr         (wr),
      .rd         (rd),
      .data_out   (data_out)
   );

   always #(CLK_PERIOD / 2) nclk = ~nclk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1, "simulation aborted");
   endtask

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic load_stim();
      integer      fd;
      integer      n;
      integer      got;
      string       line;
      logic [31:0] f_init, f_ract, f_raddr, f_wact, f_waddr, f_data, f_exp;
      stim_line_t  sl;
      fd = $fopen("dv/bht_stim.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open the stimulus file dv/bht_stim.txt");
      end else begin
         n = $fgets(line, fd);
         while (n != 0) begin
            // skip comments and empty lines
            if (line.len() > 1 && line.getc(0) != "#") begin
               got = $sscanf(line, "%h %h %h %h %h %h %h",
                             f_init, f_ract, f_raddr, f_wact, f_waddr, f_data, f_exp);
               if (got != 7) begin
                  stop_run($sformatf("malformed line in the stimulus file: %s", line));
               end else begin
                  sl.init       = f_init[0];
                  sl.rd.r_act   = f_ract[0];
                  sl.rd.r_addr  = f_raddr[`BHT_ADDR_W-1:0];
                  sl.wr.w_act   = f_wact[`BHT_LANES-1:0];
                  sl.wr.w_addr  = f_waddr[`BHT_ADDR_W-1:0];
                  sl.wr.data_in = f_data[`BHT_CNT_W-1:0];
                  sl.exp        = f_exp[$bits(bht_entry_t)-1:0];
                  stim_q.push_back(sl);
               end
            end
            n = $fgets(line, fd);
         end
         $fclose(fd);
         if (stim_q.size() == 0) begin
            stop_run("the stimulus file holds no stimulus lines");
         end
      end
   endtask

   task automatic drive(input logic i, input bht_rd_req_t r, input bht_wr_req_t w,
                        input logic fchk, input bht_entry_t fexp);
      @(posedge nclk);
      init_reset <= i;
      rd         <= r;
      wr         <= w;
      cur_fchk   <= fchk & r.r_act;
      cur_fexp   <= fexp;
   endtask

   // a same-address write replaces the written lanes of the read result
   function automatic bht_entry_t merge_through(input rd_stage_t st, input bht_wr_req_t w);
      bht_entry_t res;
      res = st.ent;
      if (w.w_addr == st.addr) begin
         for (int l = 0; l < `BHT_LANES; l++) begin
            if (w.w_act[l]) begin
               res[l] = w.data_in;
            end
         end
      end
      return res;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------
   always @(posedge nclk) begin
      bht_entry_t nxt;
      if (reset) begin
         model_sweep <= '0;
         s1          <= '0;
         s1_wr       <= '0;
         exp_out     <= '0;
         out_fchk    <= 1'b0;
         out_fexp    <= '0;
      end else begin
         out_fchk <= s1.act & s1.fchk;
         out_fexp <= s1.fexp;
         if (s1.act) begin
            exp_out <= merge_through(s1, s1_wr);
         end
         // array read sees the contents from before this edge
         s1.act  <= rd.r_act;
         s1.addr <= rd.r_addr;
         s1.ent  <= model_ent[rd.r_addr];
         s1.fchk <= cur_fchk;
         s1.fexp <= cur_fexp;
         s1_wr   <= wr;
         if (init_reset) begin
            model_ent[{model_sweep, 1'b0}] <= CLEARED;
            model_ent[{model_sweep, 1'b1}] <= CLEARED;
            model_sweep <= model_sweep + ONE_ROW;
         end else if (|wr.w_act &&
                      !(rd.r_act && rd.r_addr[`BHT_ADDR_W-1:1] == wr.w_addr[`BHT_ADDR_W-1:1])) begin
            nxt = model_ent[wr.w_addr];
            for (int l = 0; l < `BHT_LANES; l++) begin
               if (wr.w_act[l]) begin
                  nxt[l] = wr.data_in;
               end
            end
            model_ent[wr.w_addr] <= nxt;
         end
      end
   end

   always @(negedge nclk) begin
      if (!reset) begin
         check(data_out, exp_out, "data_out against model");
         if (out_fchk) begin
            check(data_out, out_fexp, "data_out against stimulus file");
         end
      end
   end

   // watchdog, twice the expected run length
   initial begin
      longint limit_ns;
      wait (stim_loaded === 1'b1);
      limit_ns = 2 * (INIT_CYCLES + stim_q.size() + RAND_CYCLES + RESET_CYCLES) * CLK_PERIOD;
      #(limit_ns);
      stop_run("watchdog expired before the test sequence finished");
   end

   initial begin
      bht_rd_req_t r;
      bht_wr_req_t w;
      logic [31:0] rv;
      reset       = 1'b1;
      nclk        = 1'b0;
      init_reset  = 1'b0;
      wr          = '0;
      rd          = '0;
      cur_fchk    = 1'b0;
      cur_fexp    = '0;
      seed        = 27;
      stim_loaded = 1'b0;
      load_stim();
      stim_loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge nclk);
      reset <= 1'b0;

      // clear every row
      repeat (INIT_CYCLES) drive(1'b1, '0, '0, 1'b0, '0);

      foreach (stim_q[i]) begin
         drive(stim_q[i].init, stim_q[i].rd, stim_q[i].wr, 1'b1, stim_q[i].exp);
      end

      // narrow address range so rows collide often
      repeat (RAND_CYCLES) begin
         rv        = $random(seed);
         r.r_act   = rv[0];
         r.r_addr  = {{(`BHT_ADDR_W-4){1'b0}}, rv[4:1]};
         w.w_act   = rv[5] ? rv[9:6] : '0;
         w.w_addr  = {{(`BHT_ADDR_W-4){1'b0}}, rv[13:10]};
         w.data_in = rv[15:14];
         drive(1'b0, r, w, 1'b0, '0);
      end

      repeat (4) drive(1'b0, '0, '0, 1'b0, '0);
      @(negedge nclk);
      $display("TEST PASS");
      $finish;
   end

endmodule

/* sources.f */
+incdir+logic
logic/bht_pkg.sv
logic/bht_array.sv
logic/bht_init_sweep.sv
logic/bht_write_arb.sv
logic/bht_read_path.sv
logic/bht_top.sv
dv/bht_tb.sv

/* run.sh */
#!/bin/sh
# build the branch history table testbench with Verilator and run it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f sources.f --top-module bht_tb -o bht_sim

./obj_dir/bht_sim

/* dv/bht_stim.txt */
# init r_act r_addr w_act w_addr data_in exp, all hex, one line per clock cycle
# exp is the entry that the read on this line returns, ignored when r_act is 0
0 1 000 0 000 0 55
0 1 3ff 0 000 0 55
0 0 000 1 010 3 00
0 0 000 c 011 2 00
0 1 010 0 000 0 57
0 1 011 0 000 0 a5
0 0 000 0 000 0 00
0 0 000 0 000 0 00
0 1 020 6 020 0 41
0 1 020 0 000 0 55
0 1 030 f 031 3 55
0 1 031 0 000 0 55
0 1 010 2 040 2 57
0 1 040 0 000 0 59
0 0 000 8 041 0 00
0 1 041 0 000 0 15
0 0 000 1 010 0 00
0 1 010 0 000 0 54
0 1 011 f 100 3 a5
0 1 100 0 000 0 ff
0 1 101 0 000 0 55
1 0 000 f 200 0 00
0 1 200 0 000 0 55
0 1 100 5 100 1 dd
0 1 100 0 000 0 ff
0 1 3ff 2 3fe 0 55
0 1 3fe 0 000 0 55
0 0 000 0 000 0 00
0 0 000 0 000 0 00
0 0 000 0 000 0 00
